/* filelist.f */
+incdir+hw
+incdir+verification
hw/cpu_pkg.sv
hw/stepSequencer.sv
hw/fieldDecoder.sv
hw/controlWordGen.sv
hw/cpuControl.sv
verification/tbCpuControl.sv

/* verification/controlModel.svh */
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

// Opcode in 31:27, ra in 26:23, rb in 22:19, rc in 18:15 and the constant in 18:0.

function automatic step_e dispatchStep(logic [4:0] op);
	case (op)
		5'd0: return ld0;
		5'd1: return ldi0;
		5'd2: return st0;
		5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9, 5'd10, 5'd11: return aluReg0;
		5'd12, 5'd13, 5'd14: return aluImm0;
		5'd17, 5'd18: return unary0;
		5'd19: return br0;
		5'd20: return jal0;
		5'd21: return jr0;
		5'd22: return in0;
		5'd23: return out0;
		5'd27: return halt0;
		default: return nop0; // Unused codes fall back to nop.
	endcase
endfunction

function automatic step_e nextStepOf(step_e s, logic [4:0] op);
	case (s)
		resetStep: return fetch0;
		fetch0: return fetch1;
		fetch1: return fetch2;
		fetch2: return dispatchStep(op);
		ld0: return ld1;
		ld1: return ld2;
		ld2: return ld3;
		st0: return st1;
		st1: return st2;
		st2: return st3;
		ldi0: return ldi1;
		aluReg0: return aluReg1;
		aluImm0: return aluImm1;
		unary0: return unary1;
		br0: return br1;
		jal0: return jal1;
		ld3, in0, out0, nop0: return fetch1;
		ldi1, aluReg1, aluImm1, unary1: return fetch2;
		st3, br1, jal1, jr0: return fetch0;
		halt0, done: return done;
		default: return resetStep;
	endcase
endfunction

function automatic aluOp_e expectedAluOp(logic [4:0] op);
	case (op)
		5'd0, 5'd1, 5'd2, 5'd3, 5'd12: return aluAdd;
		5'd4: return aluSub;
		5'd5, 5'd13: return aluAnd;
		5'd6, 5'd14: return aluOr;
		5'd7: return aluRor;
		5'd8: return aluRol;
		5'd9: return aluShr;
		5'd10: return aluShra;
		5'd11: return aluShl;
		5'd17: return aluNeg;
		5'd18: return aluNot;
		default: return aluNone;
	endcase
endfunction

function automatic controlWord_s expectedCtrl(step_e s, logic [31:0] w);
	controlWord_s c;
	logic pcGroup;
	c = '0;
	pcGroup = 1'b0;
	case (s)
		resetStep: c.conReset = 1'b1;
		fetch0, nop0: pcGroup = 1'b1;
		fetch1, ld2: c.read = 1'b1;
		fetch2: begin
			c.read = 1'b1;
			c.mdrIn = 1'b1;
			c.mdrFromMem = 1'b1;
			c.irIn = 1'b1;
			c.busC = srcMdr;
		end
		ld0, ldi0, st0, aluReg0, aluImm0, unary0: begin
			c.busB = srcReg;
			c.zIn = 1'b1;
			c.aluOp = expectedAluOp(w[31:27]);
			c.baseAddr = s inside {ld0, ldi0, st0};
			pcGroup = !(s inside {ld0, st0}); // ld and st advance the PC later.
			if (s == aluReg0)
				c.busC = srcReg;
			else if (s != unary0)
				c.busC = srcConst;
		end
		ldi1, aluReg1, aluImm1, unary1: begin
			c.busA = srcZLow;
			c.read = 1'b1;
		end
		ld1, st1: begin
			c.busA = srcZLow;
			c.marIn = 1'b1;
		end
		ld3: begin
			c.read = 1'b1;
			c.mdrIn = 1'b1;
			c.mdrFromMem = 1'b1;
			c.busA = srcMdr;
			pcGroup = 1'b1;
		end
		st2: begin
			c.busA = srcReg;
			c.mdrIn = 1'b1;
		end
		st3: c.writeMem = 1'b1;
		br0: begin
			c.busA = srcReg;
			c.conIn = 1'b1;
		end
		br1: begin
			c.incPc = 1'b1;
			c.pcIn = 1'b1;
			c.branch = 1'b1;
			c.conReset = 1'b1;
		end
		jal0: c.busA = srcPc;
		jal1, jr0: begin
			c.busA = srcReg;
			c.pcIn = 1'b1;
		end
		in0: begin
			c.busA = srcInPort;
			pcGroup = 1'b1;
		end
		out0: begin
			c.busA = srcReg;
			c.outPortIn = 1'b1;
			pcGroup = 1'b1;
		end
		default: ;
	endcase
	if (pcGroup) begin
		c.incPc = 1'b1;
		c.marIn = 1'b1;
		c.pcIn = 1'b1;
	end
	return c;
endfunction

function automatic regMask_t oneHot(logic [3:0] idx);
	regMask_t m;
	m = '0;
	m[idx] = 1'b1;
	return m;
endfunction

task automatic expectedMasks(input step_e s, input logic [31:0] w, output regMask_t rin,
		output regMask_t outA, output regMask_t outB, output regMask_t outC);
	rin = '0;
	outA = '0;
	outB = '0;
	outC = '0;
	if (s inside {ld3, ldi1, aluReg1, aluImm1, unary1, in0})
		rin = oneHot(w[26:23]);
	if (s == jal0)
		rin = oneHot(4'(`LINK_REG)); // Return address.
	if (s inside {st2, br0, jal1, jr0, out0})
		outA = oneHot(w[26:23]);
	if (s inside {ld0, ldi0, st0, aluReg0, aluImm0, unary0})
		outB = oneHot(w[22:19]);
	if (s == aluReg0)
		outC = oneHot(w[18:15]);
endtask

function automatic word_t signExtend(logic [31:0] w);
	return word_t'($signed(w[`CONST_W-1:0]));
endfunction

`endif

/* verification/tbCpuControl.sv */
`include "cpu_cfg.svh"

module tbCpuControl;
	timeunit 1ns;
	timeprecision 100ps;
	import cpu_pkg::*;

	`include "controlModel.svh"

	logic clk;
	logic reset;
	logic stop;
	logic [31:0] ir;
	logic run;
	controlWord_s ctrl;
	regMask_t regIn;
	regMask_t regOutA;
	regMask_t regOutB;
	regMask_t regOutC;
	word_t constSign;

	step_e modelStep;
	step_e prevStep;
	logic modelRun;
	int errors;
	int checks;
	int resetLeft;
	int doneCycles;
	logic forceHalt;
	logic keepDone;

	cpuControl uut (
		.clk(clk),
		.reset(reset),
		.stop(stop),
		.ir(ir),
		.run(run),
		.ctrl(ctrl),
		.regIn(regIn),
		.regOutA(regOutA),
		.regOutB(regOutB),
		.regOutC(regOutC),
		.constSign(constSign)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	function automatic logic [31:0] randomInstr(logic halt);
		logic [31:0] w;
		int pick;
		int idx;
		w = $urandom;
		pick = $urandom_range(99);
		if (halt || pick < 2) begin
			w[31:27] = 5'd27;
		end else if (pick < 12) begin
			// Unassigned codes 15, 16, 24, 25 and 28 to 31.
			idx = $urandom_range(7);
			w[31:27] = 5'(idx < 2 ? 15 + idx : (idx < 4 ? 22 + idx : 24 + idx));
		end else begin
			// Kept codes 0 to 14, 17 to 23 and 26.
			idx = $urandom_range(22);
			w[31:27] = 5'(idx < 15 ? idx : (idx < 22 ? idx + 2 : 26));
		end
		return w;
	endfunction

	task automatic checkValue(string name, logic [63:0] expected, logic [63:0] actual);
		checks++;
		assert (actual === expected)
		else begin
			errors++;
			$display("FAIL t=%0t %s expected %0h got %0h", $time, name, expected, actual);
		end
	endtask

	task automatic compareOutputs();
		regMask_t expIn;
		regMask_t expA;
		regMask_t expB;
		regMask_t expC;
		expectedMasks(modelStep, ir, expIn, expA, expB, expC);
		checkValue("ctrl", expectedCtrl(modelStep, ir), ctrl);
		checkValue("regIn", expIn, regIn);
		checkValue("regOutA", expA, regOutA);
		checkValue("regOutB", expB, regOutB);
		checkValue("regOutC", expC, regOutC);
		checkValue("constSign", signExtend(ir), constSign);
		checkValue("run", modelRun, run);
		assert (!(ctrl.read && ctrl.writeMem))
		else begin
			errors++;
			$display("Memory read and write strobes were high together at t=%0t.", $time);
		end
	endtask

	// Models one edge, drives the next inputs and checks at the falling edge.
	task automatic stepCycle();
		@(posedge clk);
		prevStep = modelStep;
		if (reset) begin
			modelStep = resetStep;
			modelRun = 1'b0;
		end else begin
			modelRun = !stop;
			if (!stop)
				modelStep = nextStepOf(modelStep, ir[31:27]);
		end
		if (modelStep == done && !reset)
			doneCycles++;
		else
			doneCycles = 0;
		if (doneCycles == 6 && !keepDone)
			resetLeft = 2; // Leave done only through reset.
		reset <= (resetLeft > 0);
		if (resetLeft > 0)
			resetLeft--;
		stop <= ($urandom_range(19) == 0);
		if (modelStep == fetch2 && prevStep != fetch2)
			ir <= randomInstr(forceHalt); // New word as IR loads.
		@(negedge clk);
		compareOutputs();
	endtask

	initial begin
		int waited;
		void'($urandom(32'hda71cde7));
		reset = 1'b1;
		stop = 1'b0;
		ir = '0;
		errors = 0;
		checks = 0;
		resetLeft = 1;
		doneCycles = 0;
		forceHalt = 1'b0;
		keepDone = 1'b0;
		modelStep = resetStep;
		modelRun = 1'b0;
		for (int i = 0; i < 2000; i++)
			stepCycle();

		forceHalt = 1'b1;
		keepDone = 1'b1;
		waited = 0;
		while (modelStep != done && waited < 200) begin
			stepCycle();
			waited++;
		end
		if (modelStep != done) begin
			errors++;
			$display("Timed out waiting for the done step after a forced halt.");
		end else begin
			for (int i = 0; i < 10; i++)
				stepCycle(); // Must stay idle.
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* hw/cpuControl.sv */
module cpuControl (
	input logic clk,
	input logic reset,
	input logic stop,
	input cpu_pkg::instrWord_u ir,
	output logic run,
	output cpu_pkg::controlWord_s ctrl,
	output cpu_pkg::regMask_t regIn,
	output cpu_pkg::regMask_t regOutA,
	output cpu_pkg::regMask_t regOutB,
	output cpu_pkg::regMask_t regOutC,
	output cpu_pkg::word_t constSign
);
	import cpu_pkg::*;

	step_e step;
	regMask_t raMask;
	regMask_t rbMask;
	regMask_t rcMask;
	aluOp_e aluOp;

	stepSequencer sequencer (
		.clk(clk),
		.reset(reset),
		.stop(stop),
		.opcode(ir.regView.opcode),
		.step(step),
		.run(run)
	);

	fieldDecoder decoder (
		.ir(ir),
		.raMask(raMask),
		.rbMask(rbMask),
		.rcMask(rcMask),
		.constSign(constSign),
		.aluOp(aluOp)
	);

	controlWordGen wordGen (
		.step(step),
		.raMask(raMask),
		.rbMask(rbMask),
		.rcMask(rcMask),
		.aluOp(aluOp),
		.ctrl(ctrl),
		.regIn(regIn),
		.regOutA(regOutA),
		.regOutB(regOutB),
		.regOutC(regOutC)
	);

endmodule

/* hw/controlWordGen.sv */
`include "cpu_cfg.svh"

module controlWordGen (
	input cpu_pkg::step_e step,
	input cpu_pkg::regMask_t raMask,
	input cpu_pkg::regMask_t rbMask,
	input cpu_pkg::regMask_t rcMask,
	input cpu_pkg::aluOp_e aluOp,
	output cpu_pkg::controlWord_s ctrl,
	output cpu_pkg::regMask_t regIn,
	output cpu_pkg::regMask_t regOutA,
	output cpu_pkg::regMask_t regOutB,
	output cpu_pkg::regMask_t regOutC
);
	import cpu_pkg::*;

	logic pcAdvance; // incPc, marIn, pcIn together.
	logic writeReg;
	logic writeLink;
	logic readA;
	logic readB;
	logic readC;

	always_comb begin
		ctrl = '0;
		pcAdvance = 1'b0;
		writeReg = 1'b0;
		writeLink = 1'b0;
		readA = 1'b0;
		readB = 1'b0;
		readC = 1'b0;
		case (step)
			resetStep: ctrl.conReset = 1'b1;
			fetch0: pcAdvance = 1'b1;
			fetch1: ctrl.read = 1'b1;
			fetch2: begin
				ctrl.read = 1'b1;
				ctrl.mdrIn = 1'b1;
				ctrl.mdrFromMem = 1'b1;
				ctrl.irIn = 1'b1;
				ctrl.busC = srcMdr;
			end
			ld0, ldi0, st0: begin
				// Base register plus constant.
				ctrl.baseAddr = 1'b1;
				ctrl.busB = srcReg;
				ctrl.busC = srcConst;
				ctrl.zIn = 1'b1;
				ctrl.aluOp = aluOp;
				readB = 1'b1;
				pcAdvance = (step == ldi0);
			end
			aluReg0, aluImm0, unary0: begin
				ctrl.busB = srcReg;
				ctrl.zIn = 1'b1;
				ctrl.aluOp = aluOp;
				readB = 1'b1;
				pcAdvance = 1'b1;
				if (step == aluReg0) begin
					ctrl.busC = srcReg;
					readC = 1'b1;
				end else if (step == aluImm0) begin
					ctrl.busC = srcConst;
				end
			end
			ldi1, aluReg1, aluImm1, unary1: begin
				ctrl.busA = srcZLow;
				ctrl.read = 1'b1; // Opens the next fetch early.
				writeReg = 1'b1;
			end
			ld1, st1: begin
				ctrl.busA = srcZLow;
				ctrl.marIn = 1'b1;
			end
			ld2: ctrl.read = 1'b1;
			ld3: begin
				ctrl.read = 1'b1;
				ctrl.mdrIn = 1'b1;
				ctrl.mdrFromMem = 1'b1;
				ctrl.busA = srcMdr;
				writeReg = 1'b1;
				pcAdvance = 1'b1;
			end
			st2: begin
				ctrl.busA = srcReg;
				ctrl.mdrIn = 1'b1;
				readA = 1'b1;
			end
			st3: ctrl.writeMem = 1'b1;
			br0: begin
				ctrl.busA = srcReg;
				ctrl.conIn = 1'b1;
				readA = 1'b1;
			end
			br1: begin
				// PC takes the offset only when CON is set.
				ctrl.incPc = 1'b1;
				ctrl.pcIn = 1'b1;
				ctrl.branch = 1'b1;
				ctrl.conReset = 1'b1;
			end
			jal0: begin
				ctrl.busA = srcPc;
				writeLink = 1'b1;
			end
			jal1, jr0: begin
				ctrl.busA = srcReg;
				ctrl.pcIn = 1'b1;
				readA = 1'b1;
			end
			in0: begin
				ctrl.busA = srcInPort;
				writeReg = 1'b1;
				pcAdvance = 1'b1;
			end
			out0: begin
				ctrl.busA = srcReg;
				ctrl.outPortIn = 1'b1;
				readA = 1'b1;
				pcAdvance = 1'b1;
			end
			nop0: pcAdvance = 1'b1;
			default: ; // halt0 and done idle.
		endcase
		if (pcAdvance) begin
			ctrl.incPc = 1'b1;
			ctrl.marIn = 1'b1;
			ctrl.pcIn = 1'b1;
		end
	end

	assign regIn = writeLink ? regMask_t'(1) << `LINK_REG : (writeReg ? raMask : '0);
	assign regOutA = readA ? raMask : '0;
	assign regOutB = readB ? rbMask : '0;
	assign regOutC = readC ? rcMask : '0;

	// Memory port cannot read and write in one step.
	assert property (@(step) !(ctrl.read && ctrl.writeMem));

	assert property (@(step) $onehot0(regIn));

endmodule

/* hw/fieldDecoder.sv */
`include "cpu_cfg.svh"

module fieldDecoder (
	input cpu_pkg::instrWord_u ir,
	output cpu_pkg::regMask_t raMask,
	output cpu_pkg::regMask_t rbMask,
	output cpu_pkg::regMask_t rcMask,
	output cpu_pkg::word_t constSign,
	output cpu_pkg::aluOp_e aluOp
);
	import cpu_pkg::*;

	// ra and rb sit at the same bits in both views.
	assign raMask = regMask_t'(1) << ir.immView.ra;
	assign rbMask = regMask_t'(1) << ir.immView.rb;
	assign rcMask = regMask_t'(1) << ir.regView.rc;

	assign constSign = {{(`WORD_W-`CONST_W){ir.immView.imm[`CONST_W-1]}}, ir.immView.imm};

	always_comb begin
		case (ir.regView.opcode)
			opLd, opLdi, opSt, opAdd, opAddi: aluOp = aluAdd; // Address calc uses add.
			opSub: aluOp = aluSub;
			opAnd, opAndi: aluOp = aluAnd;
			opOr, opOri: aluOp = aluOr;
			opRor: aluOp = aluRor;
			opRol: aluOp = aluRol;
			opShr: aluOp = aluShr;
			opShra: aluOp = aluShra;
			opShl: aluOp = aluShl;
			opNeg: aluOp = aluNeg;
			opNot: aluOp = aluNot;
			default: aluOp = aluNone;
		endcase
	end

endmodule

/* hw/stepSequencer.sv */
module stepSequencer (
	input logic clk,
	input logic reset,
	input logic stop,
	input cpu_pkg::opcode_e opcode,
	output cpu_pkg::step_e step,
	output logic run
);
	import cpu_pkg::*;

	step_e nextStep;

	always_comb begin
		case (step)
			resetStep: nextStep = fetch0;
			fetch0: nextStep = fetch1;
			fetch1: nextStep = fetch2;
			fetch2: begin
				// Dispatch on the word just latched in IR.
				case (opcode)
					opLd: nextStep = ld0;
					opLdi: nextStep = ldi0;
					opSt: nextStep = st0;
					opAdd, opSub, opAnd, opOr, opRor,
					opRol, opShr, opShra, opShl: nextStep = aluReg0;
					opAddi, opAndi, opOri: nextStep = aluImm0;
					opNeg, opNot: nextStep = unary0;
					opBr: nextStep = br0;
					opJal: nextStep = jal0;
					opJr: nextStep = jr0;
					opIn: nextStep = in0;
					opOut: nextStep = out0;
					opHalt: nextStep = halt0;
					default: nextStep = nop0; // Unassigned codes too.
				endcase
			end
			ld0: nextStep = ld1;
			ld1: nextStep = ld2;
			ld2: nextStep = ld3;
			ld3: nextStep = fetch1; // MAR already holds PC.
			ldi0: nextStep = ldi1;
			ldi1: nextStep = fetch2;
			st0: nextStep = st1;
			st1: nextStep = st2;
			st2: nextStep = st3;
			st3: nextStep = fetch0;
			aluReg0: nextStep = aluReg1;
			aluReg1: nextStep = fetch2;
			aluImm0: nextStep = aluImm1;
			aluImm1: nextStep = fetch2;
			unary0: nextStep = unary1;
			unary1: nextStep = fetch2;
			br0: nextStep = br1;
			br1: nextStep = fetch0;
			jal0: nextStep = jal1;
			jal1: nextStep = fetch0;
			jr0: nextStep = fetch0;
			in0: nextStep = fetch1;
			out0: nextStep = fetch1;
			nop0: nextStep = fetch1;
			halt0: nextStep = done;
			done: nextStep = done;
			default: nextStep = resetStep;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			step <= resetStep;
			run <= 1'b0;
		end else begin
			run <= !stop;
			if (!stop)
				step <= nextStep; // Frozen while stopped.
		end
	end

	// Only reset leaves the halted state.
	assert property (@(posedge clk) disable iff (reset)
		step == done |=> step == done);

	assert property (@(posedge clk) disable iff (reset)
		stop |=> $stable(step));

endmodule

/* hw/cpu_pkg.sv */
`include "cpu_cfg.svh"

package cpu_pkg;

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`REG_COUNT-1:0] regMask_t;
	typedef logic [`REG_FIELD_W-1:0] regField_t;

	// Reference encoding. Gaps are unassigned and run as nop.
	typedef enum logic [`OPCODE_W-1:0] {
		opLd = 5'd0,
		opLdi = 5'd1,
		opSt = 5'd2,
		opAdd = 5'd3,
		opSub = 5'd4,
		opAnd = 5'd5,
		opOr = 5'd6,
		opRor = 5'd7,
		opRol = 5'd8,
		opShr = 5'd9,
		opShra = 5'd10,
		opShl = 5'd11,
		opAddi = 5'd12,
		opAndi = 5'd13,
		opOri = 5'd14,
		opNeg = 5'd17,
		opNot = 5'd18,
		opBr = 5'd19,
		opJal = 5'd20,
		opJr = 5'd21,
		opIn = 5'd22,
		opOut = 5'd23,
		opNop = 5'd26,
		opHalt = 5'd27
	} opcode_e;

	typedef enum logic [6:0] {
		resetStep,
		fetch0, fetch1, fetch2,
		ld0, ld1, ld2, ld3,
		ldi0, ldi1,
		st0, st1, st2, st3,
		aluReg0, aluReg1,
		aluImm0, aluImm1,
		unary0, unary1,
		br0, br1,
		jal0, jal1,
		jr0,
		in0,
		out0,
		nop0,
		halt0,
		done
	} step_e;

	typedef enum logic [2:0] {
		srcNone = 3'd0, // Bus floats to zero.
		srcReg,
		srcZLow,
		srcPc,
		srcMdr,
		srcInPort,
		srcConst
	} busSrc_e;

	typedef enum logic [3:0] {
		aluNone = 4'd0,
		aluAdd, aluSub, aluAnd, aluOr,
		aluRor, aluRol, aluShr, aluShra, aluShl,
		aluNeg, aluNot
	} aluOp_e;

	typedef struct packed {
		opcode_e opcode;
		regField_t ra;
		regField_t rb;
		regField_t rc;
		logic [`WORD_W-`OPCODE_W-3*`REG_FIELD_W-1:0] unused;
	} regForm_s;

	typedef struct packed {
		opcode_e opcode;
		regField_t ra;
		regField_t rb;
		logic [`CONST_W-1:0] imm;
	} immForm_s;

	// Same IR bits, read as three registers or as two plus a constant.
	typedef union packed {
		regForm_s regView;
		immForm_s immView;
	} instrWord_u;

	typedef struct packed {
		busSrc_e busA;
		busSrc_e busB;
		busSrc_e busC;
		aluOp_e aluOp;
		logic incPc;
		logic pcIn;
		logic irIn;
		logic zIn;
		logic yIn;
		logic marIn;
		logic mdrIn;
		logic mdrFromMem; // MDR takes memory data, not the bus.
		logic read;
		logic writeMem;
		logic conIn;
		logic conReset;
		logic branch;
		logic baseAddr; // r0 reads as zero.
		logic outPortIn;
	} controlWord_s;

endpackage

/* hw/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath word.
`define WORD_W 32

// General register file.
`define REG_COUNT 16
`define REG_FIELD_W 4

// Instruction fields.
`define OPCODE_W 5
`define CONST_W 19

// Return address target of jal.
`define LINK_REG 8

`endif
